// ==== cache_cfg_pkg.sv ====
// data cache geometry
package cache_cfg_pkg;

   localparam int WORD_W    = 32;   // data and address width
   localparam int NUM_WAYS  = 2;
   localparam int NUM_SETS  = 8;
   localparam int IDX_W     = 3;    // log2 of NUM_SETS
   localparam int TAG_W     = 26;
   localparam int BLK_WORDS = 2;    // words per block

   typedef logic [WORD_W-1:0] word_t;

   // byte address split for a two word block
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      logic             blkoff;   // word inside the block
      logic [1:0]       bytoff;
   } addr_fields_t;

   // same 32 bits seen as a raw word or as cache fields
   typedef union packed {
      word_t        raw;
      addr_fields_t f;
   } dcache_addr_u;

   // one cache block with its state bits
   typedef struct packed {
      logic                         valid;
      logic                         dirty;
      logic [TAG_W-1:0]             tag;
      word_t [BLK_WORDS-1:0]        data;   // data[1] is the upper word
   } frame_t;

endpackage

// ==== cache_bus_pkg.sv ====
// core and memory bus bundles
package cache_bus_pkg;

   // request from the core, held until dhit
   typedef struct packed {
      logic                        ren;
      logic                        wen;
      logic                        halt;
      cache_cfg_pkg::dcache_addr_u addr;
      cache_cfg_pkg::word_t        wdata;
   } core_req_t;

   // answer to the core
   typedef struct packed {
      logic                 dhit;      // one cycle pulse per served request
      logic                 flushed;   // sticky once the halt flush is over
      cache_cfg_pkg::word_t rdata;
   } core_rsp_t;

   // word request towards memory
   // held with a steady address until an edge with dwait low
   typedef struct packed {
      logic                        ren;
      logic                        wen;
      cache_cfg_pkg::dcache_addr_u addr;
      cache_cfg_pkg::word_t        wdata;
   } mem_req_t;

endpackage

// ==== dcache_frames.sv ====
// cache block storage and tag lookup
`timescale 1ns/100ps

module dcache_frames (
   input  logic                                            CLK,
   input  logic                                            nRST,
   // hit lookup
   input  cache_cfg_pkg::dcache_addr_u                     lookup_addr,
   // write strobes from the controller
   input  logic                                            wr_way,
   input  logic [cache_cfg_pkg::IDX_W-1:0]                 wr_idx,
   input  logic                                            word_we,
   input  logic                                            word_off,
   input  cache_cfg_pkg::word_t                            word_data,
   input  logic                                            mark_dirty,
   input  logic                                            clean_block,
   input  logic                                            install,
   input  logic [cache_cfg_pkg::TAG_W-1:0]                 install_tag,
   // set view for the controller
   input  logic [cache_cfg_pkg::IDX_W-1:0]                 rd_idx,
   output logic                                            hit,
   output logic                                            hit_way,
   output cache_cfg_pkg::frame_t [cache_cfg_pkg::NUM_WAYS-1:0] rd_frames
);

   // state bits, one per way and set
   logic [cache_cfg_pkg::NUM_WAYS-1:0][cache_cfg_pkg::NUM_SETS-1:0] valid_q;
   logic [cache_cfg_pkg::NUM_WAYS-1:0][cache_cfg_pkg::NUM_SETS-1:0] dirty_q;

   logic [cache_cfg_pkg::TAG_W-1:0] tag_q
      [cache_cfg_pkg::NUM_WAYS][cache_cfg_pkg::NUM_SETS];
   cache_cfg_pkg::word_t [cache_cfg_pkg::BLK_WORDS-1:0] data_q
      [cache_cfg_pkg::NUM_WAYS][cache_cfg_pkg::NUM_SETS];

   logic [cache_cfg_pkg::NUM_WAYS-1:0] match;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         valid_q <= '0;   // every block invalid
         dirty_q <= '0;
      end
      else begin
         if (install) begin
            valid_q[wr_way][wr_idx] <= 1'b1;
         end
         // a freshly filled or written back block is clean
         if (install || clean_block) begin
            dirty_q[wr_way][wr_idx] <= 1'b0;
         end
         else if (mark_dirty) begin
            dirty_q[wr_way][wr_idx] <= 1'b1;   // write hit
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (word_we) begin
         data_q[wr_way][wr_idx][word_off] <= word_data;
      end
      if (install) begin
         tag_q[wr_way][wr_idx] <= install_tag;
      end
   end

   // tag compare on the indexed set of both ways
   always_comb begin
      for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
         match[w] = valid_q[w][lookup_addr.f.idx] &&
                    (tag_q[w][lookup_addr.f.idx] == lookup_addr.f.tag);
      end
   end

   assign hit     = |match;
   assign hit_way = match[1];   // way 0 unless way 1 matches

   // frames of the set chosen by the controller
   always_comb begin
      for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
         rd_frames[w].valid = valid_q[w][rd_idx];
         rd_frames[w].dirty = dirty_q[w][rd_idx];
         rd_frames[w].tag   = tag_q[w][rd_idx];
         rd_frames[w].data  = data_q[w][rd_idx];
      end
   end

endmodule

// ==== dcache_lru.sv ====
// per set recency tracking
`timescale 1ns/100ps

module dcache_lru (
   input  logic                            CLK,
   input  logic                            nRST,
   input  logic [cache_cfg_pkg::IDX_W-1:0] idx,
   input  logic                            touch,
   input  logic                            touch_way,
   output logic                            victim
);

   // one bit per set, names the way used last
   logic [cache_cfg_pkg::NUM_SETS-1:0] mru_q;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         mru_q <= '0;   // way 1 is the first victim everywhere
      end
      else if (touch) begin
         mru_q[idx] <= touch_way;
      end
   end

   // replace the way not used most recently
   assign victim = ~mru_q[idx];

endmodule

// ==== dcache_ctrl.sv ====
// data cache controller
`timescale 1ns/100ps

module dcache_ctrl (
   input  logic                                            CLK,
   input  logic                                            nRST,
   input  cache_bus_pkg::core_req_t                        core_req,
   output cache_bus_pkg::core_rsp_t                        core_rsp,
   output cache_bus_pkg::mem_req_t                         mem_req,
   input  logic                                            dwait,
   input  cache_cfg_pkg::word_t                            dload,
   input  logic                                            hit,
   input  logic                                            hit_way,
   input  logic                                            victim,
   input  cache_cfg_pkg::frame_t [cache_cfg_pkg::NUM_WAYS-1:0] rd_frames,
   output logic                                            wr_way,
   output logic [cache_cfg_pkg::IDX_W-1:0]                 wr_idx,
   output logic                                            word_we,
   output logic                                            word_off,
   output cache_cfg_pkg::word_t                            word_data,
   output logic                                            mark_dirty,
   output logic                                            clean_block,
   output logic                                            install,
   output logic [cache_cfg_pkg::TAG_W-1:0]                 install_tag,
   output logic [cache_cfg_pkg::IDX_W-1:0]                 rd_idx,
   output logic                                            touch,
   output logic                                            touch_way
);

   typedef enum logic [3:0] {
      IDLE, WB0, WB1, FILL0, FILL1, FLUSH_SCAN, FLUSH_W0, FLUSH_W1, DONE
   } state_t;

   state_t state, next_state;
   logic   vway, next_vway;                              // latched victim
   logic [cache_cfg_pkg::IDX_W:0]   flush_cnt, next_cnt;  // {way, set}
   logic [cache_cfg_pkg::IDX_W-1:0] flush_idx;
   logic   flush_way;
   logic   flushing;
   logic   cur_way;
   logic   req_acc;
   cache_cfg_pkg::frame_t cur_frame;

   assign flush_way = flush_cnt[cache_cfg_pkg::IDX_W];
   assign flush_idx = flush_cnt[cache_cfg_pkg::IDX_W-1:0];
   assign flushing  = (state == FLUSH_SCAN) || (state == FLUSH_W0) ||
                      (state == FLUSH_W1);

   // block being written back or filled
   assign cur_way   = flushing ? flush_way : vway;
   assign rd_idx    = flushing ? flush_idx : core_req.addr.f.idx;
   assign cur_frame = rd_frames[cur_way];

   assign wr_idx      = rd_idx;
   assign wr_way      = (state == IDLE) ? hit_way : cur_way;
   assign install_tag = core_req.addr.f.tag;
   assign touch_way   = hit_way;
   assign req_acc     = core_req.ren | core_req.wen;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state     <= IDLE;
         vway      <= 1'b0;
         flush_cnt <= '0;
      end
      else begin
         state     <= next_state;
         vway      <= next_vway;
         flush_cnt <= next_cnt;
      end
   end

   always_comb begin
      next_state  = state;
      next_vway   = vway;
      next_cnt    = flush_cnt;
      core_rsp    = '0;
      core_rsp.rdata = rd_frames[hit_way].data[core_req.addr.f.blkoff];
      mem_req     = '0;
      mem_req.addr.f.tag = cur_frame.tag;   // write-back target
      mem_req.addr.f.idx = rd_idx;
      word_we     = 1'b0;
      word_off    = 1'b0;
      word_data   = dload;
      mark_dirty  = 1'b0;
      clean_block = 1'b0;
      install     = 1'b0;
      touch       = 1'b0;

      case (state)
         IDLE: begin
            if (core_req.halt) begin
               next_cnt   = '0;   // way 0 set 0 first
               next_state = FLUSH_SCAN;
            end
            else if (req_acc && hit) begin
               core_rsp.dhit = 1'b1;
               touch         = 1'b1;
               if (core_req.wen) begin
                  word_we    = 1'b1;
                  word_off   = core_req.addr.f.blkoff;
                  word_data  = core_req.wdata;
                  mark_dirty = 1'b1;
               end
            end
            else if (req_acc) begin
               next_vway = victim;
               if (rd_frames[victim].valid && rd_frames[victim].dirty) begin
                  next_state = WB0;
               end
               else begin
                  next_state = FILL0;
               end
            end
         end

         WB0: begin
            mem_req.wen   = 1'b1;
            mem_req.wdata = cur_frame.data[0];
            if (!dwait) begin
               next_state = WB1;
            end
         end

         WB1: begin
            mem_req.wen           = 1'b1;
            mem_req.addr.f.blkoff = 1'b1;
            mem_req.wdata         = cur_frame.data[1];
            if (!dwait) begin
               clean_block = 1'b1;
               next_state  = FILL0;
            end
         end

         FILL0: begin
            mem_req.ren        = 1'b1;
            mem_req.addr.f.tag = core_req.addr.f.tag;   // block of the request
            if (!dwait) begin
               word_we    = 1'b1;   // word_off stays 0
               next_state = FILL1;
            end
         end

         FILL1: begin
            mem_req.ren           = 1'b1;
            mem_req.addr.f.tag    = core_req.addr.f.tag;
            mem_req.addr.f.blkoff = 1'b1;
            if (!dwait) begin
               word_we    = 1'b1;
               word_off   = 1'b1;
               install    = 1'b1;   // tag and valid with the last word
               next_state = IDLE;   // request retried as a hit
            end
         end

         FLUSH_SCAN: begin
            if (cur_frame.valid && cur_frame.dirty) begin
               next_state = FLUSH_W0;
            end
            else if (&flush_cnt) begin
               next_state = DONE;
            end
            else begin
               next_cnt = flush_cnt + 1'b1;
            end
         end

         FLUSH_W0: begin
            mem_req.wen   = 1'b1;
            mem_req.wdata = cur_frame.data[0];
            if (!dwait) begin
               next_state = FLUSH_W1;
            end
         end

         FLUSH_W1: begin
            mem_req.wen           = 1'b1;
            mem_req.addr.f.blkoff = 1'b1;
            mem_req.wdata         = cur_frame.data[1];
            if (!dwait) begin
               clean_block = 1'b1;
               if (&flush_cnt) begin
                  next_state = DONE;
               end
               else begin
                  next_cnt   = flush_cnt + 1'b1;
                  next_state = FLUSH_SCAN;
               end
            end
         end

         DONE: begin
            core_rsp.flushed = 1'b1;   // held until reset
         end

         default: begin
            next_state = IDLE;
         end
      endcase
   end

endmodule

// ==== dcache_top.sv ====
// two way write-back data cache
`timescale 1ns/100ps

module dcache_top (
   input  logic                     CLK,
   input  logic                     nRST,
   input  cache_bus_pkg::core_req_t core_req,
   output cache_bus_pkg::core_rsp_t core_rsp,
   output cache_bus_pkg::mem_req_t  mem_req,
   input  logic                     dwait,
   input  cache_cfg_pkg::word_t     dload
);

   logic                                               hit;
   logic                                               hit_way;
   logic                                               victim;
   cache_cfg_pkg::frame_t [cache_cfg_pkg::NUM_WAYS-1:0] rd_frames;

   // write strobes into the frames
   logic                            wr_way;
   logic [cache_cfg_pkg::IDX_W-1:0] wr_idx;
   logic                            word_we;
   logic                            word_off;
   cache_cfg_pkg::word_t            word_data;
   logic                            mark_dirty;
   logic                            clean_block;
   logic                            install;
   logic [cache_cfg_pkg::TAG_W-1:0] install_tag;
   logic [cache_cfg_pkg::IDX_W-1:0] rd_idx;

   logic touch;
   logic touch_way;

   dcache_frames frames (
      .CLK         (CLK),
      .nRST        (nRST),
      .lookup_addr (core_req.addr),
      .wr_way      (wr_way),
      .wr_idx      (wr_idx),
      .word_we     (word_we),
      .word_off    (word_off),
      .word_data   (word_data),
      .mark_dirty  (mark_dirty),
      .clean_block (clean_block),
      .install     (install),
      .install_tag (install_tag),
      .rd_idx      (rd_idx),
      .hit         (hit),
      .hit_way     (hit_way),
      .rd_frames   (rd_frames)
   );

   dcache_lru lru (
      .CLK       (CLK),
      .nRST      (nRST),
      .idx       (core_req.addr.f.idx),   // recency only for the request set
      .touch     (touch),
      .touch_way (touch_way),
      .victim    (victim)
   );

   dcache_ctrl ctrl (
      .CLK         (CLK),
      .nRST        (nRST),
      .core_req    (core_req),
      .core_rsp    (core_rsp),
      .mem_req     (mem_req),
      .dwait       (dwait),
      .dload       (dload),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim      (victim),
      .rd_frames   (rd_frames),
      .wr_way      (wr_way),
      .wr_idx      (wr_idx),
      .word_we     (word_we),
      .word_off    (word_off),
      .word_data   (word_data),
      .mark_dirty  (mark_dirty),
      .clean_block (clean_block),
      .install     (install),
      .install_tag (install_tag),
      .rd_idx      (rd_idx),
      .touch       (touch),
      .touch_way   (touch_way)
   );

endmodule

// ==== dcache_checker.sv ====
// data cache scoreboard
`timescale 1ns/100ps

module dcache_checker (
   input  logic                     CLK,
   input  logic                     nRST,
   input  cache_bus_pkg::core_req_t core_req,
   input  cache_bus_pkg::core_rsp_t core_rsp,
   input  cache_bus_pkg::mem_req_t  mem_req,
   input  logic                     dwait,
   input  logic [1:0]               rec_phase,   // 1 victim miss, 2 reread of A, 3 over
   input  logic                     run_done,
   output logic                     report_ready,
   output int                       fail_total
);

   localparam int T_RESET = 0;
   localparam int T_READ  = 1;
   localparam int T_FILL  = 2;
   localparam int T_WB    = 3;
   localparam int T_LRU   = 4;
   localparam int T_FLUSH = 5;

   string names [6] = '{"reset", "read data", "fill order", "write-back", "recency", "flush"};
   int    n_ok [6];
   int    n_bad [6];

   cache_cfg_pkg::word_t ref_mem [cache_cfg_pkg::word_t];   // words written by the core
   cache_cfg_pkg::word_t shadow [cache_cfg_pkg::word_t];    // words memory has received
   bit                   blk_written [cache_cfg_pkg::word_t];

   bit                   reset_window = 1'b1;
   logic                 fill_off     = 1'b0;   // next fill word of the burst
   bit                   flushed_seen = 1'b0;
   logic [1:0]           last_phase   = 2'd0;
   int                   rec_wb;
   int                   rec_rd;
   cache_cfg_pkg::word_t rec_blk;                // last block written in the victim miss

   initial report_ready = 1'b0;

   function automatic cache_cfg_pkg::word_t ref_word(input cache_cfg_pkg::word_t a);
      return ref_mem.exists(a) ? ref_mem[a] : ~a;   // unwritten words keep the fill pattern
   endfunction

   function automatic cache_cfg_pkg::word_t mem_word(input cache_cfg_pkg::word_t a);
      return shadow.exists(a) ? shadow[a] : ~a;
   endfunction

   task automatic tally(input int t, input bit ok, input string msg);
      if (ok) begin
         n_ok[t]++;
      end
      else begin
         n_bad[t]++;
         $display("[ERROR] %0t ns: %s", $time, msg);
      end
   endtask

   task automatic print_result(input int t);
      if (n_ok[t] + n_bad[t] == 0) begin
         $display("%-11s no checks were made", names[t]);
      end
      else begin
         $display("%-11s %0d checks, %0d errors", names[t], n_ok[t] + n_bad[t], n_bad[t]);
      end
   endtask

   task automatic final_report();
      int total_ok;
      tally(T_FLUSH, flushed_seen, "flushed never rose after halt");
      foreach (ref_mem[k]) begin
         tally(T_FLUSH, mem_word(k) === ref_mem[k],
               $sformatf("memory at %h holds %h, expected %h", k, mem_word(k), ref_mem[k]));
      end
      print_result(T_READ);
      print_result(T_FILL);
      print_result(T_WB);
      print_result(T_FLUSH);
      total_ok   = 0;
      fail_total = 0;
      for (int t = 0; t < 6; t++) begin
         total_ok   += n_ok[t];
         fail_total += n_bad[t];
         if (n_ok[t] + n_bad[t] == 0) begin
            fail_total++;   // a behavior that was never exercised
         end
      end
      $display("summary: %0d checks passed, %0d failed", total_ok, fail_total);
      report_ready = 1'b1;
   endtask

   always @(posedge CLK) begin : watch
      cache_cfg_pkg::word_t ca;   // core word address
      cache_cfg_pkg::word_t ma;   // memory word address
      cache_cfg_pkg::word_t mb;   // memory block address
      ca = {core_req.addr.raw[31:2], 2'b00};
      ma = {mem_req.addr.raw[31:2], 2'b00};
      mb = {ma[31:3], 3'b000};
      if (!nRST || reset_window) begin
         tally(T_RESET, !(core_rsp.dhit || core_rsp.flushed || mem_req.ren || mem_req.wen),
               "dhit, flushed, ren or wen high during or right after reset");
         if (nRST) begin
            reset_window = 1'b0;
            print_result(T_RESET);
         end
      end
      else begin
         if (core_rsp.dhit && core_req.ren) begin
            tally(T_READ, core_rsp.rdata === ref_word(ca),
                  $sformatf("read %h gave %h, expected %h", ca, core_rsp.rdata, ref_word(ca)));
         end
         if (core_rsp.dhit && core_req.wen) begin
            ref_mem[ca] = core_req.wdata;
            blk_written[{ca[31:3], 3'b000}] = 1'b1;
         end
         if (mem_req.ren && !dwait) begin
            tally(T_FILL, ma === {core_req.addr.raw[31:3], fill_off, 2'b00},
                  $sformatf("fill read %h, expected word %0d of %h", ma, fill_off, ca));
            fill_off = ~fill_off;
            if (rec_phase == 2'd2) begin
               rec_rd++;
            end
         end
         if (mem_req.wen && !dwait) begin
            tally(T_WB, mem_req.wdata === ref_word(ma),
                  $sformatf("write-back %h carried %h, expected %h", ma, mem_req.wdata,
                            ref_word(ma)));
            if (!ma[2]) begin
               tally(T_WB, blk_written.exists(mb) && blk_written[mb],
                     $sformatf("block %h written back with no core write since its fill", mb));
            end
            else begin
               blk_written[mb] = 1'b0;   // memory is up to date again
            end
            shadow[ma] = mem_req.wdata;
            if (rec_phase == 2'd1) begin
               rec_wb++;
               rec_blk = mb;
            end
         end
         if (core_rsp.flushed) begin
            flushed_seen = 1'b1;
         end
         else if (flushed_seen) begin
            tally(T_FLUSH, 1'b0, "flushed dropped after it rose");
         end
         if (rec_phase != last_phase) begin
            if (rec_phase == 2'd2) begin   // A is now on the bus
               tally(T_LRU, rec_wb == 2 && rec_blk !== {ca[31:3], 3'b000},
                     $sformatf("victim miss wrote %0d words, block %h, recent block %h",
                               rec_wb, rec_blk, {ca[31:3], 3'b000}));
            end
            else if (rec_phase == 2'd3) begin
               tally(T_LRU, rec_rd == 0, "reread of the recent block went to memory");
               print_result(T_LRU);
            end
            last_phase = rec_phase;
         end
         if (run_done && !report_ready) begin
            final_report();
         end
      end
   end

endmodule

// ==== dcache_tb.sv ====
// data cache testbench
`timescale 1ns/100ps

module dcache_tb;

   localparam int CLK_PERIOD = 10;
   localparam int N_RAND     = 200;
   localparam int N_REQ      = N_RAND + 6;   // random part, recency sequence, halt
   localparam int SEED       = 94708;

   logic                     CLK;
   logic                     nRST;
   cache_bus_pkg::core_req_t core_req;
   cache_bus_pkg::core_rsp_t core_rsp;
   cache_bus_pkg::mem_req_t  mem_req;
   logic                     dwait;
   cache_cfg_pkg::word_t     dload;
   logic [1:0]               rec_phase;
   logic                     run_done;
   logic                     report_ready;
   int                       fail_total;

   cache_cfg_pkg::word_t     mem [cache_cfg_pkg::word_t];   // sparse main memory
   logic [31:0]              stim_state;
   logic [31:0]              wait_state;

   dcache_top UUT (
      .CLK      (CLK),
      .nRST     (nRST),
      .core_req (core_req),
      .core_rsp (core_rsp),
      .mem_req  (mem_req),
      .dwait    (dwait),
      .dload    (dload)
   );

   dcache_checker scoreboard (
      .CLK          (CLK),
      .nRST         (nRST),
      .core_req     (core_req),
      .core_rsp     (core_rsp),
      .mem_req      (mem_req),
      .dwait        (dwait),
      .rec_phase    (rec_phase),
      .run_done     (run_done),
      .report_ready (report_ready),
      .fail_total   (fail_total)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic cache_cfg_pkg::word_t make_addr(
      input logic [cache_cfg_pkg::TAG_W-1:0] tag,
      input logic [cache_cfg_pkg::IDX_W-1:0] idx,
      input logic                            off
   );
      cache_cfg_pkg::dcache_addr_u u;
      u.f.tag    = tag;
      u.f.idx    = idx;
      u.f.blkoff = off;
      u.f.bytoff = 2'b00;
      return u.raw;
   endfunction

   // one core request held until dhit
   task automatic access(input logic wr, input cache_cfg_pkg::word_t addr,
                         input cache_cfg_pkg::word_t data);
      logic got;
      core_req.ren      = ~wr;
      core_req.wen      = wr;
      core_req.addr.raw = addr;
      core_req.wdata    = data;
      got = 1'b0;
      while (!got) begin
         @(posedge CLK);
         got = core_rsp.dhit;
      end
      #1;
      core_req = '0;
   endtask

   // memory write port, read data and random wait states
   always @(posedge CLK) begin : mem_port
      cache_cfg_pkg::word_t a;
      if (mem_req.wen && !dwait) begin
         mem[{mem_req.addr.raw[31:2], 2'b00}] = mem_req.wdata;
      end
      #1;
      a          = {mem_req.addr.raw[31:2], 2'b00};
      dload      = mem.exists(a) ? mem[a] : ~a;   // untouched words hold ~address
      wait_state = lcg_next(wait_state);
      dwait      = wait_state[31];   // stall about half the cycles
   end

   initial begin : watchdog
      #(N_REQ * 400 * CLK_PERIOD);
      $display("watchdog: run stopped, not finished after %0d cycles", N_REQ * 400);
      $display("Test failed");
      $finish;
   end

   initial begin : stimulus
      cache_cfg_pkg::word_t addr;
      CLK        = 1'b0;
      nRST       = 1'b0;
      core_req   = '0;
      dwait      = 1'b0;
      dload      = '0;
      rec_phase  = 2'd0;
      run_done   = 1'b0;
      stim_state = SEED;
      wait_state = lcg_next(SEED);
      repeat (8) @(posedge CLK);
      #1;
      nRST = 1'b1;
      @(posedge CLK);
      #1;
      // A and B dirty in set 5 with A used last so C pushes out B
      access(1'b1, make_addr(26'd10, 3'd5, 1'b0), 32'h0a0a_0a0a);
      access(1'b1, make_addr(26'd11, 3'd5, 1'b1), 32'h0b0b_0b0b);
      access(1'b0, make_addr(26'd10, 3'd5, 1'b0), '0);
      rec_phase = 2'd1;
      access(1'b0, make_addr(26'd12, 3'd5, 1'b0), '0);
      rec_phase = 2'd2;
      access(1'b0, make_addr(26'd10, 3'd5, 1'b1), '0);
      rec_phase = 2'd3;
      // random traffic over four tags in sets 1 and 2
      repeat (N_RAND) begin
         stim_state = lcg_next(stim_state);
         addr = make_addr({24'd0, stim_state[30:29]},
                          {1'b0, stim_state[28], ~stim_state[28]}, stim_state[27]);
         stim_state = lcg_next(stim_state);
         access(stim_state[15], addr, stim_state);
      end
      core_req.halt = 1'b1;
      while (!core_rsp.flushed) begin
         @(posedge CLK);
      end
      repeat (4) @(posedge CLK);   // flushed must hold
      #1;
      run_done = 1'b1;
      wait (report_ready === 1'b1);
      #1;
      if (fail_total == 0) begin
         $display("Test passed");
      end
      else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
cache_cfg_pkg.sv
cache_bus_pkg.sv
dcache_frames.sv
dcache_lru.sv
dcache_ctrl.sv
dcache_top.sv
dcache_checker.sv
dcache_tb.sv
